// File: source/mac_pkg.sv
package mac_pkg;

  //////////////////////////////////////////////////////////////////////
  // operand and control types
  //////////////////////////////////////////////////////////////////////

  // one operand or result word
  typedef logic [31:0] word_t;

  // operator code as carried on every request port
  typedef logic [2:0] mul_op_t;

  // bit 0 marks operand a signed and bit 1 marks operand b signed
  typedef logic [1:0] sign_t;

  // right shift applied by the halfword ops
  typedef logic [4:0] shamt_t;

  // 0 picks the low halves of a and b and 1 picks the high halves
  typedef logic subword_sel_t;

  //////////////////////////////////////////////////////////////////////
  // operator codes
  //////////////////////////////////////////////////////////////////////

  // full word multiply with add or subtract of c
  localparam mul_op_t MUL_MAC32 = 3'd0;
  localparam mul_op_t MUL_MSU32 = 3'd1;

  // halfword mac with shift and the rounding variant
  localparam mul_op_t MUL_I     = 3'd2;
  localparam mul_op_t MUL_IR    = 3'd3;

  // upper half of the 64-bit product in four steps
  localparam mul_op_t MUL_H     = 3'd4;

  // byte and halfword dot products
  localparam mul_op_t MUL_DOT8  = 3'd5;
  localparam mul_op_t MUL_DOT16 = 3'd6;

  // code 7 is left free and gives a zero result

endpackage

// File: source/mac_datapath.sv
`timescale 1ns/100ps

module mac_datapath #(
  parameter int unsigned TAG_W = 1
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // command from the arbiter
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [TAG_W-1:0]      cmd_tag_i,
  input  mac_pkg::mul_op_t      cmd_op_i,
  input  mac_pkg::sign_t        cmd_sign_i,
  input  mac_pkg::subword_sel_t cmd_sub_i,
  input  mac_pkg::shamt_t       cmd_shamt_i,
  input  mac_pkg::word_t        cmd_a_i,
  input  mac_pkg::word_t        cmd_b_i,
  input  mac_pkg::word_t        cmd_c_i,

  // registered result back to the arbiter
  output logic                  res_valid_o,
  input  logic                  res_ready_i,
  output logic [TAG_W-1:0]      res_tag_o,
  output mac_pkg::word_t        res_result_o
);

  import mac_pkg::*;

  // halfword with its extension bit
  typedef logic [16:0] hw_opnd_t;
  // halfword mac sum incl. the two carry bits of the upper-half steps
  typedef logic [33:0] hw_acc_t;

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  mulh_state_e      mulh_state_q;
  mulh_state_e      mulh_state_d;

  // handshake
  logic             cmd_accept;
  logic             res_take;
  logic             res_load;
  logic             mulh_start;
  logic             mulh_active;
  logic             mulh_save;

  // upper-half operands held for the whole sequence
  word_t            mulh_a_q;
  word_t            mulh_b_q;
  sign_t            mulh_sign_q;

  // partial sum between steps
  word_t            mulh_acc_q;
  logic [1:0]       mulh_carry_q;

  // per-step halfword controls from the fsm
  logic             mulh_sel_a;
  logic             mulh_sel_b;
  sign_t            mulh_sign;
  shamt_t           mulh_shamt;

  // halfword mac signals
  word_t            hw_word_a;
  word_t            hw_word_b;
  logic             hw_sel_a;
  logic             hw_sel_b;
  sign_t            hw_sign;
  shamt_t           hw_shamt;
  hw_opnd_t         hw_op_a;
  hw_opnd_t         hw_op_b;
  hw_acc_t          hw_op_c;
  word_t            hw_round;
  hw_acc_t          hw_mac;
  hw_acc_t          hw_shift_in;
  hw_acc_t          hw_result;

  // full word mac
  word_t            int_prod;
  word_t            int_result;

  // dot product lanes
  logic [3:0][8:0]  dot8_a;
  logic [3:0][8:0]  dot8_b;
  logic [3:0][17:0] dot8_mul;
  word_t            dot8_result;
  logic [1:0][16:0] dot16_a;
  logic [1:0][16:0] dot16_b;
  logic [1:0][33:0] dot16_mul;
  word_t            dot16_result;

  // result register
  logic             res_valid_q;
  logic [TAG_W-1:0] res_tag_q;
  word_t            res_result_q;
  word_t            res_result_d;

  // only one command in flight
  // ready when idle and the result slot is free or draining now
  assign res_take    = res_valid_q & res_ready_i;
  assign cmd_ready_o = (mulh_state_q == IDLE) & (~res_valid_q | res_ready_i);
  assign cmd_accept  = cmd_valid_i & cmd_ready_o;
  assign mulh_start  = cmd_accept & (cmd_op_i == MUL_H);
  assign mulh_active = (mulh_state_q != IDLE);

  //////////////////////////////////////////////////////////////////////
  // halfword mac
  //////////////////////////////////////////////////////////////////////

  // fsm owns the multiplier while an upper-half op runs
  assign hw_word_a = mulh_active ? mulh_a_q   : cmd_a_i;
  assign hw_word_b = mulh_active ? mulh_b_q   : cmd_b_i;
  assign hw_sel_a  = mulh_active ? mulh_sel_a : cmd_sub_i;
  assign hw_sel_b  = mulh_active ? mulh_sel_b : cmd_sub_i;
  assign hw_sign   = mulh_active ? mulh_sign  : cmd_sign_i;
  assign hw_shamt  = mulh_active ? mulh_shamt : cmd_shamt_i;

  // halfword pick and extension
  assign hw_op_a[15:0] = hw_sel_a ? hw_word_a[31:16] : hw_word_a[15:0];
  assign hw_op_b[15:0] = hw_sel_b ? hw_word_b[31:16] : hw_word_b[15:0];
  assign hw_op_a[16]   = hw_sign[0] & hw_op_a[15];
  assign hw_op_b[16]   = hw_sign[1] & hw_op_b[15];

  // accumulator input
  always_comb begin
    if (!mulh_active) begin
      hw_op_c = {2'b00, cmd_c_i};
    end else if (mulh_state_q == STEP0) begin
      // first partial product starts from zero
      hw_op_c = '0;
    end else begin
      hw_op_c = {mulh_carry_q, mulh_acc_q};
    end
  end

  // half an lsb of the shift for MUL_IR
  // zero when shamt is 0
  assign hw_round = (!mulh_active && (cmd_op_i == MUL_IR)) ?
                    ((32'd1 << cmd_shamt_i) >> 1) : '0;

  assign hw_mac = $signed(hw_op_c) + $signed(hw_op_a) * $signed(hw_op_b) +
                  $signed({2'b00, hw_round});

  // plain ops keep 33 bits
  // bit 32 only spreads further for an arithmetic shift
  assign hw_shift_in = mulh_active ? hw_mac : {hw_sign[0] & hw_mac[32], hw_mac[32:0]};
  assign hw_result   = $signed(hw_shift_in) >>> hw_shamt;

  // upper-half sequence
  // lo*lo, then hi*lo, then lo*hi, then hi*hi
  always_comb begin
    mulh_state_d = mulh_state_q;
    mulh_sel_a   = 1'b0;
    mulh_sel_b   = 1'b0;
    mulh_sign    = 2'b00;
    mulh_shamt   = 5'd0;
    mulh_save    = 1'b0;

    unique case (mulh_state_q)
      IDLE: begin
        if (mulh_start) begin
          mulh_state_d = STEP0;
        end
      end
      STEP0: begin
        // unsigned low halves and only the bits above 16 matter
        mulh_shamt   = 5'd16;
        mulh_save    = 1'b1;
        mulh_state_d = STEP1;
      end
      STEP1: begin
        mulh_sel_a   = 1'b1;
        mulh_sign    = {1'b0, mulh_sign_q[0]};
        mulh_save    = 1'b1;
        mulh_state_d = STEP2;
      end
      STEP2: begin
        // cross terms are summed so drop the next 16 bits
        mulh_sel_b   = 1'b1;
        mulh_sign    = {mulh_sign_q[1], 1'b0};
        mulh_shamt   = 5'd16;
        mulh_save    = 1'b1;
        mulh_state_d = FINISH;
      end
      FINISH: begin
        mulh_sel_a   = 1'b1;
        mulh_sel_b   = 1'b1;
        mulh_sign    = mulh_sign_q;
        mulh_state_d = IDLE;
      end
      default: begin
        mulh_state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // full word mac and msu
  //////////////////////////////////////////////////////////////////////

  // low word of the product does not depend on signedness
  assign int_prod   = cmd_a_i * cmd_b_i;
  assign int_result = (cmd_op_i == MUL_MSU32) ? (cmd_c_i - int_prod) : (cmd_c_i + int_prod);

  //////////////////////////////////////////////////////////////////////
  // dot products
  //////////////////////////////////////////////////////////////////////

  // four byte lanes
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      dot8_a[i]   = {cmd_sign_i[0] & cmd_a_i[8*i+7], cmd_a_i[8*i +: 8]};
      dot8_b[i]   = {cmd_sign_i[1] & cmd_b_i[8*i+7], cmd_b_i[8*i +: 8]};
      dot8_mul[i] = $signed(dot8_a[i]) * $signed(dot8_b[i]);
    end
  end

  assign dot8_result = $signed(dot8_mul[0]) + $signed(dot8_mul[1]) +
                       $signed(dot8_mul[2]) + $signed(dot8_mul[3]) + $signed(cmd_c_i);

  // two halfword lanes
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      dot16_a[i]   = {cmd_sign_i[0] & cmd_a_i[16*i+15], cmd_a_i[16*i +: 16]};
      dot16_b[i]   = {cmd_sign_i[1] & cmd_b_i[16*i+15], cmd_b_i[16*i +: 16]};
      dot16_mul[i] = $signed(dot16_a[i]) * $signed(dot16_b[i]);
    end
  end

  // only the low word of each lane reaches the sum
  assign dot16_result = dot16_mul[0][31:0] + dot16_mul[1][31:0] + cmd_c_i;

  //////////////////////////////////////////////////////////////////////
  // result mux and result register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (mulh_state_q == FINISH) begin
      res_result_d = hw_result[31:0];
    end else begin
      unique case (cmd_op_i)
        MUL_MAC32, MUL_MSU32: res_result_d = int_result;
        MUL_I, MUL_IR:        res_result_d = hw_result[31:0];
        MUL_DOT8:             res_result_d = dot8_result;
        MUL_DOT16:            res_result_d = dot16_result;
        // MUL_H lands in FINISH and code 7 gives zero
        default:              res_result_d = '0;
      endcase
    end
  end

  // single-step ops load at the accept edge
  assign res_load = (cmd_accept & (cmd_op_i != MUL_H)) | (mulh_state_q == FINISH);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_state_q <= IDLE;
      res_valid_q  <= 1'b0;
    end else begin
      mulh_state_q <= mulh_state_d;
      // a new load wins over a drain in the same cycle
      if (res_load) begin
        res_valid_q <= 1'b1;
      end else if (res_take) begin
        res_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mulh_start) begin
      mulh_a_q    <= cmd_a_i;
      mulh_b_q    <= cmd_b_i;
      mulh_sign_q <= cmd_sign_i;
    end
    if (mulh_save) begin
      mulh_acc_q   <= hw_result[31:0];
      mulh_carry_q <= hw_result[33:32];
    end
    // tag follows the command to its result
    if (cmd_accept) begin
      res_tag_q <= cmd_tag_i;
    end
    if (res_load) begin
      res_result_q <= res_result_d;
    end
  end

  assign res_valid_o  = res_valid_q;
  assign res_tag_o    = res_tag_q;
  assign res_result_o = res_result_q;

endmodule

// File: source/mac_port_arbiter.sv
`timescale 1ns/100ps

module mac_port_arbiter #(
  parameter int unsigned NUM_PORTS = 2,
  parameter int unsigned TAG_W     = 1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // request side of every peer port
  input  logic                  [NUM_PORTS-1:0] req_valid_i,
  output logic                  [NUM_PORTS-1:0] req_ready_o,
  input  mac_pkg::mul_op_t      [NUM_PORTS-1:0] req_op_i,
  input  mac_pkg::sign_t        [NUM_PORTS-1:0] req_sign_i,
  input  mac_pkg::subword_sel_t [NUM_PORTS-1:0] req_sub_i,
  input  mac_pkg::shamt_t       [NUM_PORTS-1:0] req_shamt_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_a_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_b_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_c_i,

  // response side of every peer port
  output logic                  [NUM_PORTS-1:0] resp_valid_o,
  input  logic                  [NUM_PORTS-1:0] resp_ready_i,
  output mac_pkg::word_t        [NUM_PORTS-1:0] resp_result_o,

  // command towards the datapath
  output logic                                  cmd_valid_o,
  input  logic                                  cmd_ready_i,
  output logic                  [TAG_W-1:0]     cmd_tag_o,
  output mac_pkg::mul_op_t                      cmd_op_o,
  output mac_pkg::sign_t                        cmd_sign_o,
  output mac_pkg::subword_sel_t                 cmd_sub_o,
  output mac_pkg::shamt_t                       cmd_shamt_o,
  output mac_pkg::word_t                        cmd_a_o,
  output mac_pkg::word_t                        cmd_b_o,
  output mac_pkg::word_t                        cmd_c_o,

  // result from the datapath
  input  logic                                  res_valid_i,
  output logic                                  res_ready_o,
  input  logic                  [TAG_W-1:0]     res_tag_i,
  input  mac_pkg::word_t                        res_result_i
);

  // round-robin priority pointer
  logic [TAG_W-1:0] ptr_q;
  logic [TAG_W-1:0] grant_idx;
  logic             grant_valid;

  // first valid port at or after the pointer
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int unsigned i = 0; i < NUM_PORTS; i++) begin
      idx = (ptr_q + i) % NUM_PORTS;
      if (!grant_valid && req_valid_i[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = TAG_W'(idx);
      end
    end
  end

  // winner's command goes out with its index as tag
  assign cmd_valid_o = grant_valid;
  assign cmd_tag_o   = grant_idx;
  assign cmd_op_o    = req_op_i[grant_idx];
  assign cmd_sign_o  = req_sign_i[grant_idx];
  assign cmd_sub_o   = req_sub_i[grant_idx];
  assign cmd_shamt_o = req_shamt_i[grant_idx];
  assign cmd_a_o     = req_a_i[grant_idx];
  assign cmd_b_o     = req_b_i[grant_idx];
  assign cmd_c_o     = req_c_i[grant_idx];

  // ready only to the winner
  // response valid decoded one-hot from the tag
  always_comb begin
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      req_ready_o[p]  = cmd_ready_i & grant_valid & (grant_idx == TAG_W'(p));
      resp_valid_o[p] = res_valid_i & (res_tag_i == TAG_W'(p));
    end
  end

  // every port sees the same result word
  assign resp_result_o = {NUM_PORTS{res_result_i}};
  assign res_ready_o   = (res_tag_i < NUM_PORTS) ? resp_ready_i[res_tag_i] : 1'b0;

  // pointer moves past the winner after each transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (cmd_valid_o && cmd_ready_i) begin
      if (grant_idx == TAG_W'(NUM_PORTS - 1)) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx + 1'b1;
      end
    end
  end

endmodule

// File: source/mac_cluster_top.sv
`timescale 1ns/100ps

module mac_cluster_top #(
  parameter int unsigned NUM_PORTS = 2,
  parameter int unsigned TAG_W     = 1
) (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // request side of each peer port
  input  logic                  [NUM_PORTS-1:0] req_valid_i,
  output logic                  [NUM_PORTS-1:0] req_ready_o,
  input  mac_pkg::mul_op_t      [NUM_PORTS-1:0] req_op_i,
  input  mac_pkg::sign_t        [NUM_PORTS-1:0] req_sign_i,
  input  mac_pkg::subword_sel_t [NUM_PORTS-1:0] req_sub_i,
  input  mac_pkg::shamt_t       [NUM_PORTS-1:0] req_shamt_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_a_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_b_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_c_i,

  // response side of each peer port
  output logic                  [NUM_PORTS-1:0] resp_valid_o,
  input  logic                  [NUM_PORTS-1:0] resp_ready_i,
  output mac_pkg::word_t        [NUM_PORTS-1:0] resp_result_o
);

  import mac_pkg::*;

  // arbiter to datapath command
  logic             cmd_valid;
  logic             cmd_ready;
  logic [TAG_W-1:0] cmd_tag;
  mul_op_t          cmd_op;
  sign_t            cmd_sign;
  subword_sel_t     cmd_sub;
  shamt_t           cmd_shamt;
  word_t            cmd_a;
  word_t            cmd_b;
  word_t            cmd_c;

  // datapath to arbiter result
  logic             res_valid;
  logic             res_ready;
  logic [TAG_W-1:0] res_tag;
  word_t            res_result;

  // round-robin front end
  mac_port_arbiter #(
    .NUM_PORTS (NUM_PORTS),
    .TAG_W     (TAG_W)
  ) i_arbiter (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_sign_i    (req_sign_i),
    .req_sub_i     (req_sub_i),
    .req_shamt_i   (req_shamt_i),
    .req_a_i       (req_a_i),
    .req_b_i       (req_b_i),
    .req_c_i       (req_c_i),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_result_o (resp_result_o),
    .cmd_valid_o   (cmd_valid),
    .cmd_ready_i   (cmd_ready),
    .cmd_tag_o     (cmd_tag),
    .cmd_op_o      (cmd_op),
    .cmd_sign_o    (cmd_sign),
    .cmd_sub_o     (cmd_sub),
    .cmd_shamt_o   (cmd_shamt),
    .cmd_a_o       (cmd_a),
    .cmd_b_o       (cmd_b),
    .cmd_c_o       (cmd_c),
    .res_valid_i   (res_valid),
    .res_ready_o   (res_ready),
    .res_tag_i     (res_tag),
    .res_result_i  (res_result)
  );

  // shared mac
  mac_datapath #(
    .TAG_W (TAG_W)
  ) i_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .cmd_tag_i    (cmd_tag),
    .cmd_op_i     (cmd_op),
    .cmd_sign_i   (cmd_sign),
    .cmd_sub_i    (cmd_sub),
    .cmd_shamt_i  (cmd_shamt),
    .cmd_a_i      (cmd_a),
    .cmd_b_i      (cmd_b),
    .cmd_c_i      (cmd_c),
    .res_valid_o  (res_valid),
    .res_ready_i  (res_ready),
    .res_tag_o    (res_tag),
    .res_result_o (res_result)
  );

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // reset low from time zero
  // released on a rising edge like every other input
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: verification/mac_checker.sv
`timescale 1ns/100ps

module mac_checker #(
  parameter int unsigned NUM_PORTS = 2
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                  [NUM_PORTS-1:0] req_valid_i,
  input  logic                  [NUM_PORTS-1:0] req_ready_i,
  input  mac_pkg::mul_op_t      [NUM_PORTS-1:0] req_op_i,
  input  mac_pkg::sign_t        [NUM_PORTS-1:0] req_sign_i,
  input  mac_pkg::subword_sel_t [NUM_PORTS-1:0] req_sub_i,
  input  mac_pkg::shamt_t       [NUM_PORTS-1:0] req_shamt_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_a_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_b_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] req_c_i,
  input  logic                  [NUM_PORTS-1:0] resp_valid_i,
  input  logic                  [NUM_PORTS-1:0] resp_ready_i,
  input  mac_pkg::word_t        [NUM_PORTS-1:0] resp_result_i,
  output int unsigned                           err_cnt_o,
  output int unsigned                           check_cnt_o,
  output int unsigned                           resp_cnt_o
);

  import mac_pkg::*;

  // expected results in acceptance order, each with its port
  word_t       exp_val[$];
  int unsigned exp_port[$];
  int unsigned exp_cycle[$];
  int unsigned exp_lat[$];

  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned resp_cnt;
  int unsigned cycle_cnt;
  logic        after_reset;
  logic        have_last;
  int unsigned last_winner;
  // response seen stalled on the previous edge
  logic        held     [NUM_PORTS];
  word_t       held_val [NUM_PORTS];
  // grants to other ports while this one waits
  int unsigned wait_cnt [NUM_PORTS];

  assign err_cnt_o   = err_cnt;
  assign check_cnt_o = check_cnt;
  assign resp_cnt_o  = resp_cnt;

  initial begin
    err_cnt     = 0;
    check_cnt   = 0;
    resp_cnt    = 0;
    cycle_cnt   = 0;
    after_reset = 1'b0;
    have_last   = 1'b0;
    last_winner = 0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      held[p]     = 1'b0;
      held_val[p] = '0;
      wait_cnt[p] = 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // halfword product plus c kept to 33 bits, then rounded and shifted
  function automatic word_t halfword_model(input mul_op_t op, input sign_t sg,
                                           input subword_sel_t sub, input shamt_t sh,
                                           input word_t a, input word_t b, input word_t c);
    logic [63:0] ha;
    logic [63:0] hb;
    logic [63:0] sum;
    logic [63:0] ext;
    ha = {48'd0, (sub ? a[31:16] : a[15:0])};
    hb = {48'd0, (sub ? b[31:16] : b[15:0])};
    if (sg[0] && ha[15]) ha[63:16] = '1;
    if (sg[1] && hb[15]) hb[63:16] = '1;
    sum = ha * hb + {32'd0, c};
    if (op == MUL_IR && sh != 0) sum = sum + (64'd1 << (sh - 1));
    ext = {31'd0, sum[32:0]};
    // arithmetic shift only when a is signed
    if (sg[0] && sum[32]) ext[63:33] = '1;
    ext = ext >> sh;
    return ext[31:0];
  endfunction

  function automatic word_t mulh_model(input sign_t sg, input word_t a, input word_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    logic [63:0] prod;
    wa   = sg[0] ? {{32{a[31]}}, a} : {32'd0, a};
    wb   = sg[1] ? {{32{b[31]}}, b} : {32'd0, b};
    prod = wa * wb;
    return prod[63:32];
  endfunction

  // lane-wise products summed onto c modulo 2^32
  function automatic word_t dot_model(input int unsigned lane_w, input sign_t sg,
                                      input word_t a, input word_t b, input word_t c);
    word_t sum;
    word_t mask;
    word_t la;
    word_t lb;
    sum  = c;
    mask = (32'd1 << lane_w) - 1;
    for (int unsigned i = 0; i < 32 / lane_w; i++) begin
      la = (a >> (i * lane_w)) & mask;
      lb = (b >> (i * lane_w)) & mask;
      if (sg[0] && la[lane_w-1]) la = la | ~mask;
      if (sg[1] && lb[lane_w-1]) lb = lb | ~mask;
      sum = sum + la * lb;
    end
    return sum;
  endfunction

  function automatic word_t expected_result(input mul_op_t op, input sign_t sg,
                                            input subword_sel_t sub, input shamt_t sh,
                                            input word_t a, input word_t b, input word_t c);
    word_t res;
    case (op)
      MUL_MAC32:     res = c + a * b;
      MUL_MSU32:     res = c - a * b;
      MUL_I, MUL_IR: res = halfword_model(op, sg, sub, sh, a, b, c);
      MUL_H:         res = mulh_model(sg, a, b);
      MUL_DOT8:      res = dot_model(8, sg, a, b, c);
      MUL_DOT16:     res = dot_model(16, sg, a, b, c);
      default:       res = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // response and arbitration checks
  //////////////////////////////////////////////////////////////////////

  // oldest outstanding entry of a port, -1 when none
  function automatic int find_head(input int unsigned port);
    int idx;
    idx = -1;
    for (int i = exp_port.size() - 1; i >= 0; i--) begin
      if (exp_port[i] == port) idx = i;
    end
    return idx;
  endfunction

  task automatic check_response(input int unsigned p);
    int head;
    head = find_head(p);
    if (!resp_valid_i[p]) begin
      if (held[p]) begin
        err_cnt++;
        $display("port %0d dropped its response before resp_ready_i went high", p);
      end
      held[p] = 1'b0;
    end else if (head < 0) begin
      err_cnt++;
      $display("port %0d raised resp_valid_o with no request outstanding", p);
      held[p] = 1'b0;
    end else begin
      check_cnt++;
      if (held[p]) begin
        if (resp_result_i[p] !== held_val[p]) begin
          err_cnt++;
          $display("** Error: resp_result_o[%0d] = %h while stalled, expected %h",
                   p, resp_result_i[p], held_val[p]);
        end
      end else if (cycle_cnt - exp_cycle[head] < exp_lat[head]) begin
        // first cycle of this response
        err_cnt++;
        $display("port %0d responded %0d cycles after acceptance, needs at least %0d",
                 p, cycle_cnt - exp_cycle[head], exp_lat[head]);
      end
      if (resp_ready_i[p]) begin
        check_cnt++;
        if (resp_result_i[p] !== exp_val[head]) begin
          err_cnt++;
          $display("** Error: resp_result_o[%0d] = %h, expected %h",
                   p, resp_result_i[p], exp_val[head]);
        end
        exp_val.delete(head);
        exp_port.delete(head);
        exp_cycle.delete(head);
        exp_lat.delete(head);
        resp_cnt++;
        held[p] = 1'b0;
      end else begin
        held[p]     = 1'b1;
        held_val[p] = resp_result_i[p];
      end
    end
  endtask

  task automatic check_fairness(input int unsigned winner);
    check_cnt++;
    // with every port waiting the grant must move on
    if (have_last && (&req_valid_i) && winner == last_winner) begin
      err_cnt++;
      $display("port %0d won twice in a row while every port was requesting", winner);
    end
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      if (p == winner || !req_valid_i[p]) begin
        wait_cnt[p] = 0;
      end else begin
        wait_cnt[p]++;
        if (wait_cnt[p] > NUM_PORTS) begin
          err_cnt++;
          $display("port %0d was passed over %0d times in a row", p, wait_cnt[p]);
        end
      end
    end
    last_winner = winner;
    have_last   = 1'b1;
  endtask

  always @(posedge clk_i) begin : monitor
    int unsigned n_acc;
    int unsigned winner;
    n_acc  = 0;
    winner = 0;
    cycle_cnt++;
    // no response during reset or on the first edge after it
    if (!rst_n_i || after_reset) begin
      check_cnt++;
      if (resp_valid_i !== '0) begin
        err_cnt++;
        $display("** Error: resp_valid_o = %h around reset, expected %h",
                 resp_valid_i, {NUM_PORTS{1'b0}});
      end
    end
    after_reset = !rst_n_i;
    if (rst_n_i) begin
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        check_response(p);
      end
      // accepted requests go into the model
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        if (req_valid_i[p] && req_ready_i[p]) begin
          exp_val.push_back(expected_result(req_op_i[p], req_sign_i[p], req_sub_i[p],
                                            req_shamt_i[p], req_a_i[p], req_b_i[p],
                                            req_c_i[p]));
          exp_port.push_back(p);
          exp_cycle.push_back(cycle_cnt);
          exp_lat.push_back((req_op_i[p] == MUL_H) ? 4 : 1);
          n_acc++;
          winner = p;
        end
      end
      if (n_acc > 1) begin
        err_cnt++;
        $display("%0d requests were accepted in the same cycle", n_acc);
      end else if (n_acc == 1) begin
        check_fairness(winner);
      end
    end
  end

endmodule

// File: verification/mac_tb.sv
`timescale 1ns/100ps

module mac_tb;

  import mac_pkg::*;

  localparam int unsigned NUM_PORTS     = 2;
  localparam int unsigned TAG_W         = 1;
  localparam int unsigned NUM_CMDS      = 1000;
  localparam int unsigned CLK_PERIOD_NS = 20;
  localparam int unsigned RESET_CYCLES  = 4;
  localparam int unsigned SEED          = 32'h00094662;
  // commands x upper-half steps x back-pressure factor x period
  localparam longint unsigned WATCHDOG_NS = NUM_PORTS * NUM_CMDS * 4 * 8 * CLK_PERIOD_NS;

  logic                                  clk;
  logic                                  rst_n;

  logic                  [NUM_PORTS-1:0] req_valid;
  logic                  [NUM_PORTS-1:0] req_ready;
  mul_op_t               [NUM_PORTS-1:0] req_op;
  sign_t                 [NUM_PORTS-1:0] req_sign;
  subword_sel_t          [NUM_PORTS-1:0] req_sub;
  shamt_t                [NUM_PORTS-1:0] req_shamt;
  word_t                 [NUM_PORTS-1:0] req_a;
  word_t                 [NUM_PORTS-1:0] req_b;
  word_t                 [NUM_PORTS-1:0] req_c;
  logic                  [NUM_PORTS-1:0] resp_valid;
  logic                  [NUM_PORTS-1:0] resp_ready;
  word_t                 [NUM_PORTS-1:0] resp_result;

  // counters reported by the checker
  int unsigned                           err_cnt;
  int unsigned                           check_cnt;
  int unsigned                           resp_cnt;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mac_cluster_top #(
    .NUM_PORTS (NUM_PORTS),
    .TAG_W     (TAG_W)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_o   (req_ready),
    .req_op_i      (req_op),
    .req_sign_i    (req_sign),
    .req_sub_i     (req_sub),
    .req_shamt_i   (req_shamt),
    .req_a_i       (req_a),
    .req_b_i       (req_b),
    .req_c_i       (req_c),
    .resp_valid_o  (resp_valid),
    .resp_ready_i  (resp_ready),
    .resp_result_o (resp_result)
  );

  mac_checker #(
    .NUM_PORTS (NUM_PORTS)
  ) i_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .req_op_i      (req_op),
    .req_sign_i    (req_sign),
    .req_sub_i     (req_sub),
    .req_shamt_i   (req_shamt),
    .req_a_i       (req_a),
    .req_b_i       (req_b),
    .req_c_i       (req_c),
    .resp_valid_i  (resp_valid),
    .resp_ready_i  (resp_ready),
    .resp_result_i (resp_result),
    .err_cnt_o     (err_cnt),
    .check_cnt_o   (check_cnt),
    .resp_cnt_o    (resp_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // random command fields
  //////////////////////////////////////////////////////////////////////

  // a quarter of the operands come from the corner list
  function automatic word_t pick_operand();
    word_t val;
    if ($urandom_range(0, 3) == 0) begin
      case ($urandom_range(0, 7))
        0:       val = 32'h0000_0000;
        1:       val = 32'h0000_0001;
        2:       val = 32'hFFFF_FFFF;
        3:       val = 32'h8000_0000;
        4:       val = 32'h7FFF_FFFF;
        5:       val = 32'h8000_8000;
        6:       val = 32'h7FFF_7FFF;
        default: val = 32'hFFFF_0000;
      endcase
    end else begin
      val = $urandom();
    end
    return val;
  endfunction

  // both shift ends show up often
  function automatic shamt_t pick_shamt();
    shamt_t sh;
    case ($urandom_range(0, 7))
      0:       sh = 5'd0;
      1:       sh = 5'd31;
      default: sh = shamt_t'($urandom_range(0, 31));
    endcase
    return sh;
  endfunction

  task automatic load_command(input int unsigned p);
    mul_op_t op;
    // the free code 7 appears now and then
    if ($urandom_range(0, 15) == 0) begin
      op = mul_op_t'(7);
    end else begin
      op = mul_op_t'($urandom_range(0, 6));
    end
    req_op[p]    <= op;
    req_sign[p]  <= sign_t'($urandom_range(0, 3));
    req_sub[p]   <= subword_sel_t'($urandom_range(0, 1));
    req_shamt[p] <= pick_shamt();
    req_a[p]     <= pick_operand();
    req_b[p]     <= pick_operand();
    req_c[p]     <= pick_operand();
    req_valid[p] <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus, run control and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int unsigned sent [NUM_PORTS];
    int unsigned gap  [NUM_PORTS];
    req_valid  = '0;
    req_op     = '0;
    req_sign   = '0;
    req_sub    = '0;
    req_shamt  = '0;
    req_a      = '0;
    req_b      = '0;
    req_c      = '0;
    resp_ready = '0;
    for (int unsigned p = 0; p < NUM_PORTS; p++) begin
      sent[p] = 0;
      gap[p]  = 0;
    end
    void'($urandom(SEED));
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      for (int unsigned p = 0; p < NUM_PORTS; p++) begin
        // mostly no idle gap after a transfer
        if (req_valid[p] && req_ready[p]) begin
          gap[p] = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 4) : 0;
        end
        // valid holds with stable data until its transfer
        if (!req_valid[p] || req_ready[p]) begin
          if (gap[p] != 0) begin
            gap[p]--;
            req_valid[p] <= 1'b0;
          end else if (sent[p] < NUM_CMDS) begin
            load_command(p);
            sent[p]++;
          end else begin
            req_valid[p] <= 1'b0;
          end
        end
        // back-pressure about one cycle in four
        resp_ready[p] <= ($urandom_range(0, 3) != 0);
      end
    end
  end

  initial begin : run_control
    wait (resp_cnt == NUM_PORTS * NUM_CMDS);
    // a few more edges to catch stray responses
    repeat (4) @(posedge clk);
    $display("responses: %0d, checks: %0d, errors: %0d", resp_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: only %0d of %0d responses arrived within %0d ns",
             resp_cnt, NUM_PORTS * NUM_CMDS, WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: build.f
source/mac_pkg.sv
source/mac_datapath.sv
source/mac_port_arbiter.sv
source/mac_cluster_top.sv
verification/tb_clk_gen.sv
verification/mac_checker.sv
verification/mac_tb.sv

// File: Bender.yml
package:
  name: mac_cluster

sources:
  - source/mac_pkg.sv
  - source/mac_datapath.sv
  - source/mac_port_arbiter.sv
  - source/mac_cluster_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/mac_checker.sv
      - verification/mac_tb.sv
